//--- common/qed_pkg.sv
// Shared widths, entry types and the lane parity function, imported by every queue entry store module
package qed_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------

    // Payload width of one queue entry as the producer sees it
    localparam int QED_DATA_W = 64;

    // One even-parity bit protects each 16-bit lane of the payload
    localparam int QED_LANES  = 4;
    localparam int QED_LANE_W = QED_DATA_W / QED_LANES;

    // ------------------------------------------------------------
    // Types
    // ------------------------------------------------------------

    // Payload as pushed by the producer and returned to the consumer
    typedef logic [QED_DATA_W-1:0] qed_data_t;

    // Stored word, 68 bits, payload in the upper bits and lane parity below
    typedef struct packed {
        qed_data_t              data;
        logic [QED_LANES-1:0]   par;
    } qed_entry_t;

    // Popped entry handed to the consumer together with its check result
    typedef struct packed {
        qed_data_t  data;
        logic       perr;
    } qed_pop_t;

    // ------------------------------------------------------------
    // Parity
    // ------------------------------------------------------------

    // Even parity per lane, bit n covers payload bits [16n+15:16n]
    // A stored word is clean when the recomputed bits equal the stored ones
    function automatic logic [QED_LANES-1:0] qed_parity(input qed_data_t data);
        logic [QED_LANES-1:0] par;
        par = '0;
        for (int lane = 0; lane < QED_LANES; lane++) begin
            par[lane] = ^data[lane*QED_LANE_W +: QED_LANE_W];
        end
        return par;
    endfunction

endpackage

//--- qed_mem/qed_rf_array.sv
// Behavioral two-port storage array with a registered read, used inside the power-gated wrapper
`timescale 1ns/1ps

module qed_rf_array import qed_pkg::*; #(
    parameter int DEPTH = 64
) (
     input  logic                       clk
    ,input  logic                       rst_n
    ,input  logic                       we
    ,input  logic [$clog2(DEPTH)-1:0]   waddr
    ,input  qed_entry_t                 wdata
    ,input  logic                       re
    ,input  logic [$clog2(DEPTH)-1:0]   raddr
    ,output qed_entry_t                 rdata
);

    // Cell array, one stored word per entry
    qed_entry_t mem [DEPTH];

    // Write takes effect on the edge where we is sampled high
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read output register, holds its value between reads
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (re) begin
            rdata <= mem[raddr];
        end
    end

endmodule

//--- qed_mem/qed_mem_rf_pg.sv
// Power-gateable register file wrapper, instantiated once by the store top level around the array
`timescale 1ns/1ps

module qed_mem_rf_pg import qed_pkg::*; #(
    parameter int DEPTH = 64
) (
     input  logic                       clk
    ,input  logic                       arst_n

    // Write port
    ,input  logic                       we
    ,input  logic [$clog2(DEPTH)-1:0]   waddr
    ,input  qed_entry_t                 wdata

    // Read port
    ,input  logic                       re
    ,input  logic [$clog2(DEPTH)-1:0]   raddr
    ,output qed_entry_t                 rdata

    // Power interface, high on the enable means asleep
    ,input  logic                       pwr_enable_b_in
    ,output logic                       pwr_enable_b_out
    ,output logic                       mem_down
);

    localparam int AW = $clog2(DEPTH);

    logic [1:0]     rst_sync;
    logic           rst_n_sync;
    logic [1:0]     pwr_chain;
    logic           we_gated;
    logic           re_gated;
    qed_entry_t     rdata_arr;

    // ------------------------------------------------------------
    // Reset synchronizer for the array side
    // ------------------------------------------------------------

    // Assertion is immediate, release takes two clock edges
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign rst_n_sync = rst_sync[1];

    // ------------------------------------------------------------
    // Power switch chain
    // ------------------------------------------------------------

    // Two flops stand in for the daisy-chained power switches of the macro
    // Reset leaves the array asleep until the enable propagates through
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_chain <= 2'b11;
        end else begin
            pwr_chain <= {pwr_chain[0], pwr_enable_b_in};
        end
    end

    assign pwr_enable_b_out = pwr_chain[1];

    // Memory counts as down while any switch is still off or the array is in reset
    assign mem_down = pwr_enable_b_in | pwr_enable_b_out | ~rst_n_sync;

    // No access reaches the array while it has no supply
    assign we_gated = we & ~mem_down;
    assign re_gated = re & ~mem_down;

    // ------------------------------------------------------------
    // Storage array
    // ------------------------------------------------------------

    qed_rf_array #(
        .DEPTH      (DEPTH)
    ) u_rf (
         .clk       (clk)
        ,.rst_n     (rst_n_sync)
        ,.we        (we_gated)
        ,.waddr     (waddr[AW-1:0])
        ,.wdata     (wdata)
        ,.re        (re_gated)
        ,.raddr     (raddr[AW-1:0])
        ,.rdata     (rdata_arr)
    );

    // Isolation clamps the read data to zero while the array is down
    assign rdata = mem_down ? '0 : rdata_arr;

endmodule

//--- src/qed_enq.sv
// Input side of the entry store, adds lane parity and writes accepted pushes into the ring
`timescale 1ns/1ps

module qed_enq import qed_pkg::*; #(
    parameter int DEPTH = 64
) (
     input  logic                       clk
    ,input  logic                       arst_n

    // Producer side
    ,input  logic                       push
    ,input  qed_data_t                  push_data
    ,input  logic                       push_perr_inject

    // Status from the memory and the output side
    ,input  logic                       mem_down
    ,input  logic [$clog2(DEPTH):0]     rptr
    ,output logic [$clog2(DEPTH):0]     wptr
    ,output logic                       full

    // Write port of the memory
    ,output logic                       we
    ,output logic [$clog2(DEPTH)-1:0]   waddr
    ,output qed_entry_t                 wdata
);

    localparam int AW = $clog2(DEPTH);

    logic push_ok;

    // ------------------------------------------------------------
    // Ring status
    // ------------------------------------------------------------

    // Full when the indices match and the wrap bits differ
    assign full = (wptr[AW] != rptr[AW]) && (wptr[AW-1:0] == rptr[AW-1:0]);

    // Pushes that hit a full ring or a sleeping memory are dropped
    assign push_ok = push & ~full & ~mem_down;

    // ------------------------------------------------------------
    // Stored word
    // ------------------------------------------------------------

    // Lane 0 parity is flipped on request so the consumer sees a checked error
    always_comb begin
        wdata.data = push_data;
        wdata.par  = qed_parity(push_data) ^ {{(QED_LANES-1){1'b0}}, push_perr_inject};
    end

    assign we    = push_ok;
    assign waddr = wptr[AW-1:0];

    // Write pointer carries one wrap bit above the address
    // Contents are lost on power-down so the pointer goes back to zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wptr <= '0;
        end else if (mem_down) begin
            wptr <= '0;
        end else if (push_ok) begin
            wptr <= wptr + 1'b1;
        end
    end

endmodule

//--- src/qed_deq.sv
// Output side of the entry store, reads the ring on pop and returns each entry with a parity flag
`timescale 1ns/1ps

module qed_deq import qed_pkg::*; #(
    parameter int DEPTH = 64
) (
     input  logic                       clk
    ,input  logic                       arst_n

    // Consumer strobe
    ,input  logic                       pop

    // Status from the memory and the input side
    ,input  logic                       mem_down
    ,input  logic [$clog2(DEPTH):0]     wptr
    ,output logic [$clog2(DEPTH):0]     rptr
    ,output logic                       empty

    // Read port of the memory
    ,output logic                       re
    ,output logic [$clog2(DEPTH)-1:0]   raddr
    ,input  qed_entry_t                 rdata

    // Consumer result, one pulse per accepted pop
    ,output logic                       pop_valid
    ,output qed_pop_t                   pop_out
);

    localparam int AW = $clog2(DEPTH);

    logic                   pop_ok;
    logic                   rd_vld;
    logic [QED_LANES-1:0]   par_calc;
    logic                   perr;

    // ------------------------------------------------------------
    // Ring status and read issue
    // ------------------------------------------------------------

    // Empty when both pointers agree, wrap bit included
    assign empty = (rptr == wptr);

    // Pops on an empty ring or a sleeping memory are dropped
    assign pop_ok = pop & ~empty & ~mem_down;

    // The read goes out in the same cycle the pop is accepted
    assign re    = pop_ok;
    assign raddr = rptr[AW-1:0];

    // Read pointer returns to zero with the write pointer on power-down
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rptr <= '0;
        end else if (mem_down) begin
            rptr <= '0;
        end else if (pop_ok) begin
            rptr <= rptr + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Read pipeline
    // ------------------------------------------------------------

    // Stage one marks data arriving from the array register, stage two is the result
    // Reads in flight at power-down still finish and then drain to zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_vld    <= 1'b0;
            pop_valid <= 1'b0;
        end else begin
            rd_vld    <= pop_ok;
            pop_valid <= rd_vld;
        end
    end

    // Recompute lane parity on the returned payload and compare with the stored bits
    assign par_calc = qed_parity(rdata.data);
    assign perr     = |(par_calc ^ rdata.par);

    // Result register only loads when a read is returning
    always_ff @(posedge clk) begin
        if (rd_vld) begin
            pop_out.data <= rdata.data;
            pop_out.perr <= perr;
        end
    end

endmodule

//--- src/qed_store_top.sv
// Top level of the queue entry store, connects input side, power-gated memory and output side
`timescale 1ns/1ps

module qed_store_top import qed_pkg::*; #(
    parameter int DEPTH = 64
) (
     input  logic       clk
    ,input  logic       arst_n

    // Producer
    ,input  logic       push
    ,input  qed_data_t  push_data
    ,input  logic       push_perr_inject
    ,output logic       full

    // Consumer
    ,input  logic       pop
    ,output logic       empty
    ,output logic       pop_valid
    ,output qed_pop_t   pop_out

    // Power
    ,input  logic       pwr_enable_b_in
    ,output logic       pwr_enable_b_out
);

    localparam int AW = $clog2(DEPTH);

    // Pointers are one bit wider than the address for the wrap flag
    logic [AW:0]    wptr;
    logic [AW:0]    rptr;
    logic           we;
    logic [AW-1:0]  waddr;
    qed_entry_t     wdata;
    logic           re;
    logic [AW-1:0]  raddr;
    qed_entry_t     rdata;
    logic           mem_down;

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------

    qed_enq #(
        .DEPTH              (DEPTH)
    ) u_enq (
         .clk               (clk)
        ,.arst_n            (arst_n)
        ,.push              (push)
        ,.push_data         (push_data)
        ,.push_perr_inject  (push_perr_inject)
        ,.mem_down          (mem_down)
        ,.rptr              (rptr)
        ,.wptr              (wptr)
        ,.full              (full)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
    );

    // ------------------------------------------------------------
    // Memory
    // ------------------------------------------------------------

    qed_mem_rf_pg #(
        .DEPTH              (DEPTH)
    ) u_mem (
         .clk               (clk)
        ,.arst_n            (arst_n)
        ,.we                (we)
        ,.waddr             (waddr)
        ,.wdata             (wdata)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)
        ,.pwr_enable_b_in   (pwr_enable_b_in)
        ,.pwr_enable_b_out  (pwr_enable_b_out)
        ,.mem_down          (mem_down)
    );

    // ------------------------------------------------------------
    // Output side
    // ------------------------------------------------------------

    qed_deq #(
        .DEPTH              (DEPTH)
    ) u_deq (
         .clk               (clk)
        ,.arst_n            (arst_n)
        ,.pop               (pop)
        ,.mem_down          (mem_down)
        ,.wptr              (wptr)
        ,.rptr              (rptr)
        ,.empty             (empty)
        ,.re                (re)
        ,.raddr             (raddr)
        ,.rdata             (rdata)
        ,.pop_valid         (pop_valid)
        ,.pop_out           (pop_out)
    );

endmodule

//--- tests/qed_asserts.sv
// Concurrent assertions on the entry store top level, attached to it by a bind in the testbench
`timescale 1ns/1ps

module qed_asserts (
     input  logic   clk
    ,input  logic   arst_n
    ,input  logic   pop
    ,input  logic   full
    ,input  logic   empty
    ,input  logic   mem_down
    ,input  logic   pop_valid
    ,input  logic   pwr_enable_b_in
    ,input  logic   pwr_enable_b_out
);

    // Number of assertion failures so far
    int     fail_cnt = 0;
    logic   pop_ok;

    // A pop counts only on a non-empty ring with the memory up
    assign pop_ok = pop & ~empty & ~mem_down;

    // The result pulse comes two edges after the accepted pop and never on its own
    pop_latency: assert property (@(posedge clk) disable iff (!arst_n)
        pop_valid == $past(pop_ok, 2))
        else begin
            fail_cnt++;
            $error("pop_valid does not follow an accepted pop by two cycles");
        end

    // Both status levels at once would mean the pointers disagree on the wrap
    status_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(full && empty))
        else begin
            fail_cnt++;
            $error("full and empty are high together");
        end

    // Two switch stages sit between the power enable input and output
    // Until two edges have passed since reset the chain still holds its asleep value
    pwr_chain: assert property (@(posedge clk) disable iff (!arst_n)
        pwr_enable_b_out == (($past(arst_n) && $past(arst_n, 2)) ? $past(pwr_enable_b_in, 2)
                                                                  : 1'b1))
        else begin
            fail_cnt++;
            $error("pwr_enable_b_out is not the input delayed by two cycles");
        end

endmodule

//--- tests/qed_checker.sv
// Scoreboard of the entry store testbench, compares each pop result and the ring status with the model
`timescale 1ns/1ps

module qed_checker import qed_pkg::*; (
     input  logic       clk

    // Expectations from the reference model, stable from one rising edge to the next
    ,input  logic       exp_valid
    ,input  logic       exp_zero
    ,input  qed_pop_t   exp_entry
    ,input  logic       exp_full
    ,input  logic       exp_empty

    // Observed DUT outputs
    ,input  logic       pop_valid
    ,input  qed_pop_t   pop_out
    ,input  logic       full
    ,input  logic       empty

    // Counts for the closing line and the drain wait
    ,output int         data_errs
    ,output int         pulse_errs
    ,output int         pending
);

    qed_pop_t   exp_q [$];
    int         due_q [$];
    int         cycle = 0;

    initial begin
        data_errs  = 0;
        pulse_errs = 0;
        pending    = 0;
    end

    // ------------------------------------------------------------
    // Comparison on the falling edge, where DUT outputs are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin : compare
        qed_pop_t head;
        cycle = cycle + 1;

        // A read cut off by power-down returns isolated zeros, which pass the parity check
        if (exp_zero && exp_q.size() > 0) begin
            exp_q[exp_q.size()-1] = '0;
        end

        // The pulse is due on the next falling edge, two edges after the pop was driven
        if (exp_valid) begin
            exp_q.push_back(exp_entry);
            due_q.push_back(cycle + 1);
        end

        if (exp_q.size() > 0 && due_q[0] < cycle) begin
            $display("Missing pop_valid pulse for an accepted pop, noticed at time %0t", $time);
            pulse_errs++;
            exp_q.delete(0);
            due_q.delete(0);
        end

        if (pop_valid) begin
            if (exp_q.size() == 0 || due_q[0] != cycle) begin
                $display("Unexpected pop_valid pulse with no pop due, at time %0t", $time);
                pulse_errs++;
            end else begin
                head = exp_q.pop_front();
                due_q.delete(0);
                if (pop_out.data !== head.data) begin
                    $display("error %0t: pop data %h, expected %h", $time, pop_out.data, head.data);
                    data_errs++;
                end
                if (pop_out.perr !== head.perr) begin
                    $display("error %0t: parity flag %b, expected %b", $time, pop_out.perr,
                        head.perr);
                    data_errs++;
                end
            end
        end

        // Ring status levels against the model count
        if (full !== exp_full) begin
            $display("error %0t: full is %b, expected %b", $time, full, exp_full);
            data_errs++;
        end
        if (empty !== exp_empty) begin
            $display("error %0t: empty is %b, expected %b", $time, empty, exp_empty);
            data_errs++;
        end

        pending = exp_q.size();
    end

endmodule

//--- tests/qed_tb.sv
// Top-level testbench of the entry store, drives LFSR traffic and predicts results with a queue model
`timescale 1ns/1ps

module qed_tb import qed_pkg::*; ();

    localparam int DEPTH    = 64;
    localparam int RAND_LEN = 400;
    // Reset, fill and drain, parity, random with drain, power-down, plus margin
    localparam int LIMIT    = 24 + 140 + 24 + (RAND_LEN + 80) + 100 + 200;

    logic           clk;
    logic           arst_n;
    logic           push;
    qed_data_t      push_data;
    logic           push_perr_inject;
    logic           pop;
    logic           pwr_enable_b_in;
    logic           full;
    logic           empty;
    logic           pop_valid;
    qed_pop_t       pop_out;
    logic           pwr_enable_b_out;

    // Reference model state, all written on the rising edge
    qed_pop_t       ref_q [$];
    logic [1:0]     rst_m;
    logic [1:0]     pwr_m;
    logic           last_pop;
    logic           exp_valid = 1'b0;
    logic           exp_zero = 1'b0;
    qed_pop_t       exp_entry = '0;
    logic           exp_full = 1'b0;
    logic           exp_empty = 1'b1;
    logic [31:0]    lfsr;
    int             cyc = 0;
    int             data_errs;
    int             pulse_errs;
    int             pending;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    qed_store_top #(.DEPTH(DEPTH)) uut (
        .clk(clk), .arst_n(arst_n), .push(push), .push_data(push_data),
        .push_perr_inject(push_perr_inject), .full(full), .pop(pop), .empty(empty),
        .pop_valid(pop_valid), .pop_out(pop_out), .pwr_enable_b_in(pwr_enable_b_in),
        .pwr_enable_b_out(pwr_enable_b_out)
    );

    qed_checker u_chk (
        .clk(clk), .exp_valid(exp_valid), .exp_zero(exp_zero), .exp_entry(exp_entry),
        .exp_full(exp_full), .exp_empty(exp_empty), .pop_valid(pop_valid), .pop_out(pop_out),
        .full(full), .empty(empty), .data_errs(data_errs), .pulse_errs(pulse_errs),
        .pending(pending)
    );

    bind qed_store_top qed_asserts u_asserts (
        .clk(clk), .arst_n(arst_n), .pop(pop), .full(full), .empty(empty),
        .mem_down(mem_down), .pop_valid(pop_valid), .pwr_enable_b_in(pwr_enable_b_in),
        .pwr_enable_b_out(pwr_enable_b_out)
    );

    // ------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------

    // Returns {push accepted, pop accepted} for the ring occupancy before the edge
    function automatic logic [1:0] ref_accept(input logic p, input logic q, input int cnt,
                                              input logic down);
        logic push_ok;
        logic pop_ok;
        push_ok = p && !down && (cnt < DEPTH);
        pop_ok  = q && !down && (cnt > 0);
        return {push_ok, pop_ok};
    endfunction

    always @(posedge clk) begin : model_step
        logic [1:0] acc;
        logic       down;
        qed_pop_t   ent;
        exp_valid = 1'b0;
        exp_zero  = 1'b0;
        if (!arst_n) begin
            rst_m    = 2'b00;
            pwr_m    = 2'b11;
            last_pop = 1'b0;
            ref_q.delete();
        end else begin
            // Down while either switch stage is off or the array reset is still held
            down = pwr_enable_b_in | pwr_m[1] | ~rst_m[1];
            acc  = ref_accept(push, pop, ref_q.size(), down);
            exp_zero = last_pop & down;
            if (acc[0]) begin
                exp_entry = ref_q.pop_front();
                exp_valid = 1'b1;
            end
            if (acc[1]) begin
                // The flag is set exactly when lane 0 parity was inverted on the write
                ent.data = push_data;
                ent.perr = push_perr_inject;
                ref_q.push_back(ent);
            end
            // Power loss wipes the contents
            if (down) begin
                ref_q.delete();
            end
            last_pop = acc[0];
            rst_m = {rst_m[0], 1'b1};
            pwr_m = {pwr_m[0], pwr_enable_b_in};
        end
        exp_full  = (ref_q.size() == DEPTH);
        exp_empty = (ref_q.size() == 0);
    end

    // ------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit, newest bit in the LSB
    task automatic rand_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[62:0], lfsr[0]};
        end
    endtask

    // Inputs change 1 ns after the rising edge and hold for one cycle
    task automatic drive_cycle(input logic p, input qed_data_t d, input logic inj, input logic q);
        push             = p;
        push_data        = d;
        push_perr_inject = inj;
        pop              = q;
        @(posedge clk);
        #1;
    endtask

    task automatic pop_until_empty();
        while (!empty) begin
            drive_cycle(1'b0, '0, 1'b0, 1'b1);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b0);
    endtask

    // Idle until every expected pulse has been seen or declared missing
    task automatic wait_drained();
        repeat (2) drive_cycle(1'b0, '0, 1'b0, 1'b0);
        while (pending != 0) begin
            drive_cycle(1'b0, '0, 1'b0, 1'b0);
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------
    initial begin : stimulus
        logic [63:0]    r;
        logic [63:0]    d;
        int             total;
        lfsr             = 32'h363c8b9f;
        arst_n           = 1'b0;
        push             = 1'b0;
        push_data        = '0;
        push_perr_inject = 1'b0;
        pop              = 1'b0;
        pwr_enable_b_in  = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Pushes and pops while the synchronizer and power chain still hold the memory down
        // A push taken here would leave the ring non-empty for the pop behind it
        for (int i = 0; i < 2; i++) begin
            rand_bits(64, d);
            drive_cycle(1'b1, d, 1'b0, 1'b1);
        end
        repeat (4) drive_cycle(1'b0, '0, 1'b0, 1'b0);

        // Fill past full, then drain back to back
        for (int i = 0; i < DEPTH + 1; i++) begin
            rand_bits(64, d);
            drive_cycle(1'b1, d, 1'b0, 1'b0);
        end
        for (int i = 0; i < DEPTH; i++) begin
            drive_cycle(1'b0, '0, 1'b0, 1'b1);
        end
        wait_drained();

        // Injected parity errors between clean neighbours
        for (int i = 0; i < 6; i++) begin
            rand_bits(64, d);
            drive_cycle(1'b1, d, (i == 1) || (i == 4), 1'b0);
        end
        pop_until_empty();
        wait_drained();

        // Random traffic, first half leaning to pushes, second half to pops
        for (int i = 0; i < RAND_LEN; i++) begin
            rand_bits(6, r);
            rand_bits(64, d);
            if (i < RAND_LEN / 2) begin
                drive_cycle(r[0] | r[1], d, r[4] & r[5], r[2]);
            end else begin
                drive_cycle(r[0], d, r[4] & r[5], r[2] | r[3]);
            end
        end
        pop_until_empty();
        wait_drained();

        // Power-down with the ring half full and one read still in flight
        for (int i = 0; i < DEPTH / 2; i++) begin
            rand_bits(64, d);
            drive_cycle(1'b1, d, 1'b0, 1'b0);
        end
        drive_cycle(1'b0, '0, 1'b0, 1'b1);
        pwr_enable_b_in = 1'b1;
        for (int i = 0; i < 10; i++) begin
            rand_bits(2, r);
            rand_bits(64, d);
            drive_cycle(r[0], d, 1'b0, r[1]);
        end
        pwr_enable_b_in = 1'b0;
        repeat (4) drive_cycle(1'b0, '0, 1'b0, 1'b0);
        for (int i = 0; i < 8; i++) begin
            rand_bits(64, d);
            drive_cycle(1'b1, d, 1'b0, 1'b0);
        end
        pop_until_empty();
        wait_drained();

        total = data_errs + pulse_errs + uut.u_asserts.fail_cnt;
        $display("Error counts: data %0d, pulse %0d, assertion %0d", data_errs, pulse_errs,
            uut.u_asserts.fail_cnt);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
common/qed_pkg.sv
qed_mem/qed_rf_array.sv
qed_mem/qed_mem_rf_pg.sv
src/qed_enq.sv
src/qed_deq.sv
src/qed_store_top.sv
tests/qed_asserts.sv
tests/qed_checker.sv
tests/qed_tb.sv

//--- run.sh
#!/bin/sh
# Builds the entry store testbench with Verilator, runs it and looks for the pass line in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ps --top-module qed_tb \
    -f vlog.f > build.log 2>&1 &&
./obj_dir/Vqed_tb +verilator+error+limit+1000 > sim.log 2>&1 ||
{ echo "Build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "^TEST OK$" sim.log && echo "Simulation passed" ||
{ echo "Simulation failed, see sim.log"; exit 1; }
